// ==== mem_subsystem.f ====
verilog/lsq_pkg.sv
verilog/lsq.sv
verilog/load_tracker.sv
verilog/dcache.sv
verilog/mem_subsystem.sv
bench/mem_subsystem_tb.sv

// ==== bench/mem_subsystem_tb.sv ====
module mem_subsystem_tb
    import lsq_pkg::*;
();

    localparam int LSQ_SIZE        = 8;
    localparam int CACHE_LINES     = 16;
    localparam int MISS_LATENCY    = 6;
    localparam int MEM_WORDS       = 256;
    localparam int NUM_TESTS       = 6;
    localparam int CYCLES_PER_TEST = 200;

    logic     clk;
    logic     reset;
    logic     dispatch_valid;
    logic     dispatch_is_store;
    rob_tag_t dispatch_rob_tag;
    rob_tag_t dispatch_data_tag;
    logic     dispatch_data_valid;
    word_t    dispatch_data;
    logic     addr_valid;
    rob_tag_t addr_tag;
    addr_t    addr;
    logic     cdb_in_valid;
    rob_tag_t cdb_in_tag;
    word_t    cdb_in_value;
    logic     retire_valid;
    rob_tag_t retire_tag;
    logic     cdb_valid;
    rob_tag_t cdb_tag;
    word_t    cdb_value;
    logic     store_ready;
    rob_tag_t store_ready_tag;
    logic     stall_dispatch;

    // reference copy of backing memory
    word_t model_mem [MEM_WORDS];
    // broadcasts seen on the cdb, in arrival order
    rob_tag_t got_tags [$];
    word_t    got_vals [$];
    // expected results for unordered compare
    rob_tag_t exp_tags [$];
    word_t    exp_vals [$];

    logic [31:0] lfsr = 32'd92384;
    string test_name = "none";
    int    error_count = 0;
    int    errors_at_start = 0;
    int    tests_run = 0;
    int    tests_failed = 0;

    mem_subsystem #(
        .LSQ_SIZE     (LSQ_SIZE),
        .CACHE_LINES  (CACHE_LINES),
        .MISS_LATENCY (MISS_LATENCY),
        .MEM_WORDS    (MEM_WORDS)
    ) u_dut (
        .clk (clk), .reset (reset),
        .dispatch_valid (dispatch_valid), .dispatch_is_store (dispatch_is_store),
        .dispatch_rob_tag (dispatch_rob_tag), .dispatch_data_tag (dispatch_data_tag),
        .dispatch_data_valid (dispatch_data_valid), .dispatch_data (dispatch_data),
        .addr_valid (addr_valid), .addr_tag (addr_tag), .addr (addr),
        .cdb_in_valid (cdb_in_valid), .cdb_in_tag (cdb_in_tag),
        .cdb_in_value (cdb_in_value),
        .retire_valid (retire_valid), .retire_tag (retire_tag),
        .cdb_valid (cdb_valid), .cdb_tag (cdb_tag), .cdb_value (cdb_value),
        .store_ready (store_ready), .store_ready_tag (store_ready_tag),
        .stall_dispatch (stall_dispatch)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ends a hung run
    // budget scales with the test count
    initial begin
        repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clk);
        $display("timeout: test %s never completed, run stopped", test_name);
        $display("TEST FAIL");
        $finish;
    end

    // every broadcast is recorded so none is missed while stimulus runs
    always @(negedge clk) begin
        if (!reset && cdb_valid) begin
            got_tags.push_back(cdb_tag);
            got_vals.push_back(cdb_value);
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    // one step per bit
    function automatic word_t rand_word();
        word_t w;
        logic  fb;
        w = '0;
        for (int b = 0; b < 32; b++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            w    = {w[30:0], fb};
        end
        return w;
    endfunction

    task automatic check_tag(input rob_tag_t exp, input rob_tag_t act);
        if (exp !== act) begin
            $display("error %s: expected tag %0d, actual tag %0d", test_name, exp, act);
            error_count++;
        end
    endtask

    task automatic check_word(input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("error %s: expected %h, actual %h", test_name, exp, act);
            error_count++;
        end
    endtask

    task automatic report(input string what);
        $display("%s: %s", test_name, what);
        error_count++;
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = error_count;
        tests_run++;
    endtask

    task automatic end_test();
        if (error_count == errors_at_start) begin
            $display("test %s passed", test_name);
        end else begin
            $display("test %s failed, %0d errors", test_name, error_count - errors_at_start);
            tests_failed++;
        end
    endtask

    // each driver holds its inputs for exactly one edge
    task automatic do_dispatch(input logic is_store, input rob_tag_t rob_tag,
                               input rob_tag_t data_tag, input logic data_valid,
                               input word_t data);
        @(posedge clk);
        dispatch_valid      <= 1'b1;
        dispatch_is_store   <= is_store;
        dispatch_rob_tag    <= rob_tag;
        dispatch_data_tag   <= data_tag;
        dispatch_data_valid <= data_valid;
        dispatch_data       <= data;
        @(posedge clk);
        dispatch_valid      <= 1'b0;
    endtask

    task automatic do_addr(input rob_tag_t tag, input int word_idx);
        @(posedge clk);
        addr_valid <= 1'b1;
        addr_tag   <= tag;
        addr       <= addr_t'(word_idx * 4);
        @(posedge clk);
        addr_valid <= 1'b0;
    endtask

    task automatic do_cdb(input rob_tag_t tag, input word_t value);
        @(posedge clk);
        cdb_in_valid <= 1'b1;
        cdb_in_tag   <= tag;
        cdb_in_value <= value;
        @(posedge clk);
        cdb_in_valid <= 1'b0;
    endtask

    task automatic do_retire(input rob_tag_t tag);
        @(posedge clk);
        retire_valid <= 1'b1;
        retire_tag   <= tag;
        @(posedge clk);
        retire_valid <= 1'b0;
    endtask

    // next broadcast taken from the cdb record
    task automatic wait_cdb(output rob_tag_t tag, output word_t value);
        while (got_tags.size() == 0) begin
            @(negedge clk);
        end
        tag   = got_tags.pop_front();
        value = got_vals.pop_front();
    endtask

    // one load result with its tag and value
    task automatic expect_load(input rob_tag_t tag, input int word_idx);
        rob_tag_t got_tag;
        word_t    got_val;
        wait_cdb(got_tag, got_val);
        check_tag(tag, got_tag);
        check_word(model_mem[word_idx], got_val);
    endtask

    // no broadcast may appear over the next cycles
    task automatic expect_quiet(input int cycles);
        repeat (cycles) @(negedge clk);
        if (got_tags.size() != 0) begin
            report($sformatf("broadcast of rob tag %0d arrived too early or unasked",
                             got_tags[0]));
            got_tags.delete();
            got_vals.delete();
        end
    endtask

    // results may come in any order
    // each expected tag must appear exactly once
    task automatic collect_set();
        rob_tag_t got_tag;
        word_t    got_val;
        int       found;
        bit       seen [16];
        for (int j = 0; j < 16; j++) begin
            seen[j] = 1'b0;
        end
        for (int k = 0; k < exp_tags.size(); k++) begin
            wait_cdb(got_tag, got_val);
            found = -1;
            for (int j = 0; j < exp_tags.size(); j++) begin
                if (exp_tags[j] == got_tag && !seen[j]) begin
                    found = j;
                end
            end
            if (found < 0) begin
                report($sformatf("unexpected or repeated broadcast of rob tag %0d", got_tag));
            end else begin
                seen[found] = 1'b1;
                check_word(exp_vals[found], got_val);
            end
        end
        exp_tags.delete();
        exp_vals.delete();
    endtask

    task automatic test_reset_load();
        start_test("reset_load");
        if (stall_dispatch || cdb_valid || store_ready) begin
            report("status outputs not low after reset");
        end
        do_dispatch(1'b0, 5'd1, '0, 1'b0, '0);
        do_addr(5'd1, 5);
        expect_load(5'd1, 5);
        end_test();
    endtask

    task automatic test_store_load();
        word_t value;
        start_test("store_load");
        value = rand_word();
        do_dispatch(1'b1, 5'd2, '0, 1'b1, value);
        @(negedge clk);
        if (store_ready) begin
            report("store_ready raised before the store had an address");
        end
        do_addr(5'd2, 20);
        @(negedge clk);
        if (!store_ready) begin
            report("store_ready low with address and data present");
        end
        check_tag(5'd2, store_ready_tag);
        do_dispatch(1'b0, 5'd3, '0, 1'b0, '0);
        do_addr(5'd3, 20);
        model_mem[20] = value;
        do_retire(5'd2);
        expect_load(5'd3, 20);
        end_test();
    endtask

    task automatic test_store_cdb();
        word_t value;
        start_test("store_cdb");
        value = rand_word();
        // data arrives later under producer tag 12
        do_dispatch(1'b1, 5'd4, 5'd12, 1'b0, '0);
        do_addr(5'd4, 33);
        @(negedge clk);
        if (store_ready) begin
            report("store_ready raised before store data arrived");
        end
        do_cdb(5'd12, value);
        @(negedge clk);
        if (!store_ready) begin
            report("store_ready low after store data arrived on the cdb");
        end
        check_tag(5'd4, store_ready_tag);
        do_dispatch(1'b0, 5'd5, '0, 1'b0, '0);
        do_addr(5'd5, 33);
        model_mem[33] = value;
        do_retire(5'd4);
        expect_load(5'd5, 33);
        end_test();
    endtask

    task automatic test_ordering();
        word_t value;
        start_test("ordering");
        value = rand_word();
        do_dispatch(1'b1, 5'd6, '0, 1'b1, value);
        do_addr(5'd6, 50);
        do_dispatch(1'b0, 5'd7, '0, 1'b0, '0);
        do_addr(5'd7, 50);
        // load is complete but stuck behind the unretired store
        expect_quiet(20);
        model_mem[50] = value;
        do_retire(5'd6);
        expect_load(5'd7, 50);
        end_test();
    endtask

    task automatic test_out_of_order();
        start_test("out_of_order");
        // warm line 8 with word 40
        do_dispatch(1'b0, 5'd10, '0, 1'b0, '0);
        do_addr(5'd10, 40);
        expect_load(5'd10, 40);
        do_dispatch(1'b0, 5'd11, '0, 1'b0, '0);
        do_dispatch(1'b0, 5'd12, '0, 1'b0, '0);
        do_dispatch(1'b0, 5'd13, '0, 1'b0, '0);
        // word 90 misses while the two word 40 loads hit
        do_addr(5'd11, 90);
        do_addr(5'd12, 40);
        do_addr(5'd13, 40);
        exp_tags.push_back(5'd11);
        exp_vals.push_back(model_mem[90]);
        exp_tags.push_back(5'd12);
        exp_vals.push_back(model_mem[40]);
        exp_tags.push_back(5'd13);
        exp_vals.push_back(model_mem[40]);
        collect_set();
        expect_quiet(2 * MISS_LATENCY);
        end_test();
    endtask

    task automatic test_full_queue();
        start_test("full_queue");
        for (int k = 0; k < LSQ_SIZE - 1; k++) begin
            do_dispatch(1'b0, rob_tag_t'(16 + k), '0, 1'b0, '0);
            exp_tags.push_back(rob_tag_t'(16 + k));
            exp_vals.push_back(model_mem[100 + k]);
        end
        @(negedge clk);
        if (!stall_dispatch) begin
            report("stall_dispatch low with a full queue");
        end
        // must be dropped while stalled
        do_dispatch(1'b0, 5'd23, '0, 1'b0, '0);
        // addresses in reverse so the head unblocks last
        for (int k = LSQ_SIZE - 2; k >= 0; k--) begin
            do_addr(rob_tag_t'(16 + k), 100 + k);
        end
        collect_set();
        // an accepted tag 23 entry would now complete
        do_addr(5'd23, 120);
        expect_quiet(3 * MISS_LATENCY);
        if (stall_dispatch) begin
            report("stall_dispatch still high after the queue drained");
        end
        end_test();
    endtask

    initial begin
        reset               = 1'b1;
        dispatch_valid      = 1'b0;
        dispatch_is_store   = 1'b0;
        dispatch_rob_tag    = '0;
        dispatch_data_tag   = '0;
        dispatch_data_valid = 1'b0;
        dispatch_data       = '0;
        addr_valid          = 1'b0;
        addr_tag            = '0;
        addr                = '0;
        cdb_in_valid        = 1'b0;
        cdb_in_tag          = '0;
        cdb_in_value        = '0;
        retire_valid        = 1'b0;
        retire_tag          = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            model_mem[i] = MEM_INIT_OFFSET + word_t'(i);
        end
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        test_reset_load();
        test_store_load();
        test_store_cdb();
        test_ordering();
        test_out_of_order();
        test_full_queue();
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
                 error_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== verilog/mem_subsystem.sv ====
module mem_subsystem
    import lsq_pkg::*;
#(
    parameter int LSQ_SIZE     = 8,
    parameter int CACHE_LINES  = 16,
    parameter int MISS_LATENCY = 6,
    parameter int MEM_WORDS    = 256
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     dispatch_valid,
    input  logic     dispatch_is_store,
    input  rob_tag_t dispatch_rob_tag,
    input  rob_tag_t dispatch_data_tag,
    input  logic     dispatch_data_valid,
    input  word_t    dispatch_data,
    input  logic     addr_valid,
    input  rob_tag_t addr_tag,
    input  addr_t    addr,
    input  logic     cdb_in_valid,
    input  rob_tag_t cdb_in_tag,
    input  word_t    cdb_in_value,
    input  logic     retire_valid,
    input  rob_tag_t retire_tag,
    output logic     cdb_valid,
    output rob_tag_t cdb_tag,
    output word_t    cdb_value,
    output logic     store_ready,
    output rob_tag_t store_ready_tag,
    output logic     stall_dispatch
);

    // queue to cache
    bus_cmd_t dcache_cmd;
    addr_t    dcache_addr;
    word_t    dcache_wdata;
    txn_tag_t dcache_accept_tag;
    // queue to tracker
    logic     issue_valid;
    txn_tag_t issue_txn;
    rob_tag_t issue_rob_tag;
    // cache to tracker
    logic     resp_valid;
    txn_tag_t resp_txn;
    word_t    resp_data;

    lsq #(
        .LSQ_SIZE (LSQ_SIZE)
    ) u_lsq (
        .clk                 (clk),
        .reset               (reset),
        .dispatch_valid      (dispatch_valid),
        .dispatch_is_store   (dispatch_is_store),
        .dispatch_rob_tag    (dispatch_rob_tag),
        .dispatch_data_tag   (dispatch_data_tag),
        .dispatch_data_valid (dispatch_data_valid),
        .dispatch_data       (dispatch_data),
        .addr_valid          (addr_valid),
        .addr_tag            (addr_tag),
        .addr                (addr),
        .cdb_in_valid        (cdb_in_valid),
        .cdb_in_tag          (cdb_in_tag),
        .cdb_in_value        (cdb_in_value),
        .retire_valid        (retire_valid),
        .retire_tag          (retire_tag),
        .dcache_accept_tag   (dcache_accept_tag),
        .dcache_cmd          (dcache_cmd),
        .dcache_addr         (dcache_addr),
        .dcache_wdata        (dcache_wdata),
        .issue_valid         (issue_valid),
        .issue_txn           (issue_txn),
        .issue_rob_tag       (issue_rob_tag),
        .store_ready         (store_ready),
        .store_ready_tag     (store_ready_tag),
        .stall_dispatch      (stall_dispatch)
    );

    load_tracker u_tracker (
        .clk           (clk),
        .reset         (reset),
        .issue_valid   (issue_valid),
        .issue_txn     (issue_txn),
        .issue_rob_tag (issue_rob_tag),
        .resp_valid    (resp_valid),
        .resp_txn      (resp_txn),
        .resp_data     (resp_data),
        .cdb_valid     (cdb_valid),
        .cdb_tag       (cdb_tag),
        .cdb_value     (cdb_value)
    );

    dcache #(
        .CACHE_LINES  (CACHE_LINES),
        .MISS_LATENCY (MISS_LATENCY),
        .MEM_WORDS    (MEM_WORDS)
    ) u_dcache (
        .clk        (clk),
        .reset      (reset),
        .cmd        (dcache_cmd),
        .addr       (dcache_addr),
        .wdata      (dcache_wdata),
        .accept_tag (dcache_accept_tag),
        .resp_valid (resp_valid),
        .resp_txn   (resp_txn),
        .resp_data  (resp_data)
    );

endmodule

// ==== verilog/dcache.sv ====
module dcache
    import lsq_pkg::*;
#(
    parameter int CACHE_LINES  = 16,
    parameter int MISS_LATENCY = 6,
    parameter int MEM_WORDS    = 256
) (
    input  logic     clk,
    input  logic     reset,
    input  bus_cmd_t cmd,
    input  addr_t    addr,
    input  word_t    wdata,
    output txn_tag_t accept_tag,
    output logic     resp_valid,
    output txn_tag_t resp_txn,
    output word_t    resp_data
);

    localparam int LINE_W = $clog2(CACHE_LINES);
    localparam int MEM_W  = $clog2(MEM_WORDS);
    localparam int TAG_W  = 30 - LINE_W;
    localparam int CNT_W  = $clog2(MISS_LATENCY + 1);

    typedef logic [TAG_W-1:0] line_tag_t;

    // backing memory and direct mapped tag array
    word_t     mem        [MEM_WORDS];
    logic      line_valid [CACHE_LINES];
    line_tag_t line_tag   [CACHE_LINES];

    // transaction slots
    slot_state_t       slot_state [1:NUM_TXN];
    logic [CNT_W-1:0]  slot_count [1:NUM_TXN];
    logic              slot_miss  [1:NUM_TXN];
    logic [LINE_W-1:0] slot_line  [1:NUM_TXN];
    line_tag_t         slot_tag   [1:NUM_TXN];
    word_t             slot_data  [1:NUM_TXN];

    logic [MEM_W-1:0]  word_idx;
    logic [LINE_W-1:0] line_idx;
    line_tag_t         req_tag;
    logic              hit;
    logic              load_accept;
    logic              new_hit_wins;
    txn_tag_t          free_slot;
    txn_tag_t          due_miss;
    txn_tag_t          due_hit;
    txn_tag_t          resp_sel;

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = MEM_INIT_OFFSET + word_t'(i);
        end
    end

    assign word_idx = addr[MEM_W+1:2];
    assign line_idx = addr[LINE_W+1:2];
    assign req_tag  = addr[31:LINE_W+2];
    assign hit      = line_valid[line_idx] && (line_tag[line_idx] == req_tag);

    // lowest free slot, lowest due slot of each kind
    always_comb begin
        free_slot = '0;
        due_miss  = '0;
        due_hit   = '0;
        for (int s = NUM_TXN; s >= 1; s--) begin
            if (slot_state[s] == slot_idle) begin
                free_slot = txn_tag_t'(s);
            end else if (slot_count[s] == CNT_W'(1)) begin
                if (slot_miss[s]) begin
                    due_miss = txn_tag_t'(s);
                end else begin
                    due_hit = txn_tag_t'(s);
                end
            end
        end
    end

    // stores never block and always get tag 1
    always_comb begin
        case (cmd)
            bus_store: accept_tag = txn_tag_t'(1);
            bus_load:  accept_tag = free_slot;
            default:   accept_tag = '0;
        endcase
    end

    assign load_accept = (cmd == bus_load) && (free_slot != '0);

    // misses keep their exact latency, a colliding hit waits a cycle
    assign resp_sel     = (due_miss != '0) ? due_miss : due_hit;
    assign new_hit_wins = load_accept && hit && (resp_sel == '0);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            resp_valid <= 1'b0;
            for (int s = 1; s <= NUM_TXN; s++) begin
                slot_state[s] <= slot_idle;
                slot_count[s] <= '0;
                slot_miss[s]  <= 1'b0;
            end
            for (int l = 0; l < CACHE_LINES; l++) begin
                line_valid[l] <= 1'b0;
            end
        end else begin
            resp_valid <= (resp_sel != '0) || new_hit_wins;
            // countdown stops at one, the slot is then due
            for (int s = 1; s <= NUM_TXN; s++) begin
                if (slot_state[s] == slot_wait && slot_count[s] > CNT_W'(1)) begin
                    slot_count[s] <= slot_count[s] - 1'b1;
                end
            end
            if (resp_sel != '0) begin
                slot_state[resp_sel] <= slot_idle;
                if (slot_miss[resp_sel]) begin
                    line_valid[slot_line[resp_sel]] <= 1'b1;
                end
            end
            if (load_accept && !new_hit_wins) begin
                slot_state[free_slot] <= slot_wait;
                slot_miss[free_slot]  <= !hit;
                slot_count[free_slot] <= hit ? CNT_W'(1) : CNT_W'(MISS_LATENCY - 1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (resp_sel != '0) begin
            resp_txn  <= resp_sel;
            resp_data <= slot_data[resp_sel];
            if (slot_miss[resp_sel]) begin
                line_tag[slot_line[resp_sel]] <= slot_tag[resp_sel];
            end
        end else if (new_hit_wins) begin
            resp_txn  <= free_slot;
            resp_data <= mem[word_idx];
        end
        // load data is read at accept so later stores cannot reach it
        if (load_accept) begin
            slot_data[free_slot] <= mem[word_idx];
            slot_line[free_slot] <= line_idx;
            slot_tag[free_slot]  <= req_tag;
        end
    end

    // write through, no allocate
    always @(posedge clk) begin
        if (cmd == bus_store) begin
            mem[word_idx] <= wdata;
        end
    end

endmodule

// ==== verilog/load_tracker.sv ====
module load_tracker
    import lsq_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    // load accepted by the cache
    input  logic     issue_valid,
    input  txn_tag_t issue_txn,
    input  rob_tag_t issue_rob_tag,
    // cache response
    input  logic     resp_valid,
    input  txn_tag_t resp_txn,
    input  word_t    resp_data,
    // result broadcast
    output logic     cdb_valid,
    output rob_tag_t cdb_tag,
    output word_t    cdb_value
);

    // one entry per live transaction tag
    logic     slot_busy    [1:NUM_TXN];
    rob_tag_t slot_rob_tag [1:NUM_TXN];

    logic resp_known;

    // only responses for a tracked load go out on the cdb
    assign resp_known = resp_valid && (resp_txn != '0) && slot_busy[resp_txn];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cdb_valid <= 1'b0;
            for (int s = 1; s <= NUM_TXN; s++) begin
                slot_busy[s] <= 1'b0;
            end
        end else begin
            cdb_valid <= resp_known;
            if (resp_known) begin
                slot_busy[resp_txn] <= 1'b0;
            end
            // a slot freed and reused in the same cycle stays busy
            if (issue_valid) begin
                slot_busy[issue_txn] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (resp_known) begin
            cdb_tag   <= slot_rob_tag[resp_txn];
            cdb_value <= resp_data;
        end
        if (issue_valid) begin
            slot_rob_tag[issue_txn] <= issue_rob_tag;
        end
    end

endmodule

// ==== verilog/lsq.sv ====
module lsq
    import lsq_pkg::*;
#(
    parameter int LSQ_SIZE = 8
) (
    input  logic     clk,
    input  logic     reset,
    // dispatch
    input  logic     dispatch_valid,
    input  logic     dispatch_is_store,
    input  rob_tag_t dispatch_rob_tag,
    input  rob_tag_t dispatch_data_tag,
    input  logic     dispatch_data_valid,
    input  word_t    dispatch_data,
    // private address channel
    input  logic     addr_valid,
    input  rob_tag_t addr_tag,
    input  addr_t    addr,
    // common data bus
    input  logic     cdb_in_valid,
    input  rob_tag_t cdb_in_tag,
    input  word_t    cdb_in_value,
    // retire
    input  logic     retire_valid,
    input  rob_tag_t retire_tag,
    // data cache
    input  txn_tag_t dcache_accept_tag,
    output bus_cmd_t dcache_cmd,
    output addr_t    dcache_addr,
    output word_t    dcache_wdata,
    // load tracker
    output logic     issue_valid,
    output txn_tag_t issue_txn,
    output rob_tag_t issue_rob_tag,
    // rob and dispatch status
    output logic     store_ready,
    output rob_tag_t store_ready_tag,
    output logic     stall_dispatch
);

    localparam int PTR_W = (LSQ_SIZE > 2) ? $clog2(LSQ_SIZE) : 1;

    typedef logic [PTR_W-1:0] ptr_t;

    // per entry control bits
    logic     ent_valid      [LSQ_SIZE];
    logic     ent_addr_valid [LSQ_SIZE];
    logic     ent_data_valid [LSQ_SIZE];
    logic     ent_retired    [LSQ_SIZE];
    // per entry payload
    logic     ent_is_store   [LSQ_SIZE];
    rob_tag_t ent_rob_tag    [LSQ_SIZE];
    addr_t    ent_addr       [LSQ_SIZE];
    rob_tag_t ent_data_tag   [LSQ_SIZE];
    word_t    ent_data       [LSQ_SIZE];

    // associative match results
    logic addr_hit   [LSQ_SIZE];
    logic data_hit   [LSQ_SIZE];
    logic retire_hit [LSQ_SIZE];

    ptr_t head_ptr;
    ptr_t tail_ptr;
    ptr_t head_next;
    ptr_t tail_next;
    logic push;
    logic pop;
    logic head_ready;
    logic take_addr;
    logic take_cdb;

    // circular increment, depth need not be a power of two
    function automatic ptr_t ptr_inc(ptr_t p);
        return (int'(p) == LSQ_SIZE - 1) ? '0 : p + 1'b1;
    endfunction

    assign head_next = ptr_inc(head_ptr);
    assign tail_next = ptr_inc(tail_ptr);

    // one slot is kept empty so head == tail means empty
    assign stall_dispatch = (tail_next == head_ptr);
    assign push = dispatch_valid && !stall_dispatch;

    // address or cdb value arriving in the dispatch cycle is caught at the tail
    assign take_addr = addr_valid && (addr_tag == dispatch_rob_tag);
    assign take_cdb  = dispatch_is_store && !dispatch_data_valid && cdb_in_valid
                       && (cdb_in_tag == dispatch_data_tag);

    always_comb begin
        for (int i = 0; i < LSQ_SIZE; i++) begin
            addr_hit[i]   = addr_valid && ent_valid[i] && !ent_addr_valid[i]
                            && (ent_rob_tag[i] == addr_tag);
            data_hit[i]   = cdb_in_valid && ent_valid[i] && ent_is_store[i]
                            && !ent_data_valid[i] && (ent_data_tag[i] == cdb_in_tag);
            retire_hit[i] = retire_valid && ent_valid[i] && ent_is_store[i]
                            && (ent_rob_tag[i] == retire_tag);
        end
    end

    // head may go to the cache
    // a store also needs its data and retirement
    assign head_ready = ent_valid[head_ptr] && ent_addr_valid[head_ptr]
                        && (!ent_is_store[head_ptr]
                            || (ent_data_valid[head_ptr] && ent_retired[head_ptr]));

    // store at head is only waiting for the rob
    assign store_ready = ent_valid[head_ptr] && ent_is_store[head_ptr]
                         && ent_addr_valid[head_ptr] && ent_data_valid[head_ptr]
                         && !ent_retired[head_ptr];
    assign store_ready_tag = ent_rob_tag[head_ptr];

    // command held until the cache hands back a nonzero tag
    assign dcache_cmd   = !head_ready ? bus_none
                          : (ent_is_store[head_ptr] ? bus_store : bus_load);
    assign dcache_addr  = ent_addr[head_ptr];
    assign dcache_wdata = ent_data[head_ptr];

    assign pop = head_ready && (dcache_accept_tag != '0);

    // accepted loads are handed to the tracker
    assign issue_valid   = pop && !ent_is_store[head_ptr];
    assign issue_txn     = dcache_accept_tag;
    assign issue_rob_tag = ent_rob_tag[head_ptr];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            for (int i = 0; i < LSQ_SIZE; i++) begin
                ent_valid[i]      <= 1'b0;
                ent_addr_valid[i] <= 1'b0;
                ent_data_valid[i] <= 1'b0;
                ent_retired[i]    <= 1'b0;
            end
        end else begin
            for (int i = 0; i < LSQ_SIZE; i++) begin
                if (addr_hit[i]) begin
                    ent_addr_valid[i] <= 1'b1;
                end
                if (data_hit[i]) begin
                    ent_data_valid[i] <= 1'b1;
                end
                if (retire_hit[i]) begin
                    ent_retired[i] <= 1'b1;
                end
            end
            if (push) begin
                ent_valid[tail_ptr]      <= 1'b1;
                ent_addr_valid[tail_ptr] <= take_addr;
                ent_data_valid[tail_ptr] <= dispatch_data_valid || take_cdb;
                ent_retired[tail_ptr]    <= 1'b0;
                tail_ptr                 <= tail_next;
            end
            // popped entry is cleared, this wins over a late retire match
            if (pop) begin
                ent_valid[head_ptr]      <= 1'b0;
                ent_addr_valid[head_ptr] <= 1'b0;
                ent_data_valid[head_ptr] <= 1'b0;
                ent_retired[head_ptr]    <= 1'b0;
                head_ptr                 <= head_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < LSQ_SIZE; i++) begin
            if (addr_hit[i]) begin
                ent_addr[i] <= addr;
            end
            if (data_hit[i]) begin
                ent_data[i] <= cdb_in_value;
            end
        end
        if (push) begin
            ent_is_store[tail_ptr] <= dispatch_is_store;
            ent_rob_tag[tail_ptr]  <= dispatch_rob_tag;
            ent_data_tag[tail_ptr] <= dispatch_data_tag;
            ent_addr[tail_ptr]     <= addr;
            ent_data[tail_ptr]     <= take_cdb ? cdb_in_value : dispatch_data;
        end
    end

endmodule

// ==== verilog/lsq_pkg.sv ====
package lsq_pkg;

    // rob tag of an instruction
    // also names the producer of an address or a store value
    typedef logic [4:0] rob_tag_t;

    // one data word
    typedef logic [31:0] word_t;

    // byte address, low two bits are not used
    typedef logic [31:0] addr_t;

    // cache transaction tag
    // zero means no transaction, 1..3 are live slots
    typedef logic [1:0] txn_tag_t;

    // number of live transaction slots
    localparam int NUM_TXN = 3;

    // cache command encoding
    typedef logic [1:0] bus_cmd_t;

    localparam bus_cmd_t bus_none  = 2'd0;
    localparam bus_cmd_t bus_load  = 2'd1;
    localparam bus_cmd_t bus_store = 2'd2;

    // miss slot state machine
    typedef enum logic {
        slot_idle,
        slot_wait
    } slot_state_t;

    // backing memory word i holds i plus this offset out of power up
    localparam word_t MEM_INIT_OFFSET = 32'h1000_0000;

endpackage
